/* common/mz_bus_pkg.sv */
package mz_bus_pkg;

        localparam int ADDR_W     = 24;         // Host address bus
        localparam int DATA_W     = 32;         // Host and RAM data
        localparam int LANES      = 4;          // Byte lanes per word
        localparam int WORD_IDX_W = 9;          // 512 RAM words

        // Host address, whole or split into word index and byte offset
        typedef union packed {
                logic [ADDR_W-1:0] raw;
                struct packed {
                        logic [ADDR_W-WORD_IDX_W-3:0] unused;   // Above the RAM window
                        logic [WORD_IDX_W-1:0]        word_idx;
                        logic [1:0]                   byte_off; // Lanes come from byte_n
                } fields;
        } mz_addr_u;

        // Bus FSM states
        typedef enum logic [2:0] {
                bus_idle,               // Wait for strobe
                bus_lanes,              // Form byte-lane writes
                bus_settle,             // Write lands
                bus_read,               // One RAM read cycle
                bus_ack,                // Raise dtack
                bus_hold,               // Until host drops as
                bus_batch               // Adder running
        } bus_state_e;

endpackage

/* common/pair_add_pkg.sv */
package pair_add_pkg;

        localparam int PAIR_COUNT   = 10;       // Operand pairs per batch
        localparam int OPERAND_BASE = 1;        // Words 1..20 hold operands
        localparam int RESULT_BASE  = 21;       // Sums go to 21..30
        localparam int TRIGGER_WORD = 0;        // Any access here starts a batch

        // Six steps per pair
        typedef enum logic [2:0] {
                fetch_a,
                take_a,
                fetch_b,
                take_b,
                write_sum,
                advance
        } add_state_e;

endpackage

/* common/ram_port_if.sv */
`timescale 1ns/1ns

interface ram_port_if;

        logic                                en;
        logic [mz_bus_pkg::LANES-1:0]        wr_lanes;  // Per byte lane
        logic [mz_bus_pkg::WORD_IDX_W-1:0]   word_idx;
        logic [mz_bus_pkg::DATA_W-1:0]       wdata;
        logic [mz_bus_pkg::DATA_W-1:0]       rdata;     // Valid cycle after en

        // Requester side
        modport master (
                output en,
                output wr_lanes,
                output word_idx,
                output wdata,
                input  rdata
        );

        // RAM side
        modport slave (
                input  en,
                input  wr_lanes,
                input  word_idx,
                input  wdata,
                output rdata
        );

endinterface

/* src/result_ram.sv */
`timescale 1ns/1ns

module result_ram (
        input  logic      buffered_clk,
        input  logic      SYS_RST_N,
        input  logic      busy,         // Sequencer owns the RAM
        ram_port_if.slave bus_port,
        ram_port_if.slave seq_port
);

        logic [mz_bus_pkg::DATA_W-1:0]     mem [2**mz_bus_pkg::WORD_IDX_W];
        logic                              en;
        logic [mz_bus_pkg::LANES-1:0]      wr_lanes;
        logic [mz_bus_pkg::WORD_IDX_W-1:0] word_idx;
        logic [mz_bus_pkg::DATA_W-1:0]     wdata;
        logic [mz_bus_pkg::DATA_W-1:0]     rd_q;        // Registered read

        // Port select
        assign en       = busy ? seq_port.en       : bus_port.en;
        assign wr_lanes = busy ? seq_port.wr_lanes : bus_port.wr_lanes;
        assign word_idx = busy ? seq_port.word_idx : bus_port.word_idx;
        assign wdata    = busy ? seq_port.wdata    : bus_port.wdata;

        assign bus_port.rdata = rd_q;
        assign seq_port.rdata = rd_q;

        always_ff @(posedge buffered_clk) begin
                if (en) begin
                        for (int i = 0; i < mz_bus_pkg::LANES; i++) begin
                                if (wr_lanes[i]) begin
                                        mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
                                end
                        end
                end
        end

        // Old contents on a write cycle
        always_ff @(posedge buffered_clk or negedge SYS_RST_N) begin
                if (!SYS_RST_N) begin
                        rd_q <= '0;
                end else if (en) begin
                        rd_q <= mem[word_idx];
                end
        end

        // Decode must release the RAM before the batch starts
        assert property (@(posedge buffered_clk) disable iff (!SYS_RST_N)
                busy |-> !bus_port.en);

endmodule

/* src/mz_bus_decode.sv */
`timescale 1ns/1ns

module mz_bus_decode (
        input  logic                          buffered_clk,
        input  logic                          SYS_RST_N,
        input  logic                          as,
        input  logic                          rw,
        input  logic                          rw_raw,
        input  logic [mz_bus_pkg::LANES-1:0]  byte_n,
        input  logic [mz_bus_pkg::ADDR_W-1:0] addr,
        input  logic [mz_bus_pkg::DATA_W-1:0] wdata,
        input  logic                          done,         // Batch finished
        output logic [mz_bus_pkg::DATA_W-1:0] rdata,
        output logic                          rdata_oe,
        output logic                          dtack,
        output logic                          start,        // One-cycle batch kick
        output logic                          idle,
        ram_port_if.master                    bus_port
);

        typedef logic [mz_bus_pkg::WORD_IDX_W-1:0] idx_t;

        logic [1:0]                    as_sync;         // Two-flop strobe sync
        logic                          as_detected;
        mz_bus_pkg::bus_state_e        state;
        mz_bus_pkg::mz_addr_u          addr_q;          // Latched host address
        logic [mz_bus_pkg::DATA_W-1:0] wdata_q;
        logic [mz_bus_pkg::DATA_W-1:0] rdata_q;         // Word for the host
        logic                          rd_wait;         // Read data one cycle out

        // ----------------------------------------------------------
        // Strobe synchronizer
        // ----------------------------------------------------------
        always_ff @(posedge buffered_clk or negedge SYS_RST_N) begin
                if (!SYS_RST_N) begin
                        as_sync <= 2'b00;
                end else begin
                        as_sync <= {as_sync[0], as};
                end
        end

        // Live pin included so a dropped strobe is seen at once
        assign as_detected = as_sync[1] && as_sync[0] && as;

        assign idle              = (state == mz_bus_pkg::bus_idle);
        assign rdata_oe          = rw && as;            // Host read cycle
        assign rdata             = rdata_q;
        assign bus_port.word_idx = addr_q.fields.word_idx;
        assign bus_port.wdata    = wdata_q;

        always_ff @(posedge buffered_clk) begin
                if (idle && as_detected) begin
                        addr_q.raw <= addr;
                        wdata_q    <= wdata;
                end
                if (state == mz_bus_pkg::bus_read && rd_wait) begin
                        rdata_q <= bus_port.rdata;      // Word after the write
                end
        end

        // ----------------------------------------------------------
        // Bus FSM
        // ----------------------------------------------------------
        always_ff @(posedge buffered_clk or negedge SYS_RST_N) begin
                if (!SYS_RST_N) begin
                        state             <= mz_bus_pkg::bus_idle;
                        bus_port.en       <= 1'b0;
                        bus_port.wr_lanes <= '0;
                        dtack             <= 1'b0;
                        start             <= 1'b0;
                        rd_wait           <= 1'b0;
                end else begin
                        start <= 1'b0;
                        case (state)
                        mz_bus_pkg::bus_idle: begin
                                dtack <= 1'b0;
                                if (as_detected) begin
                                        state <= mz_bus_pkg::bus_lanes;
                                end
                        end
                        mz_bus_pkg::bus_lanes: begin
                                if (as_detected) begin
                                        bus_port.en       <= 1'b1;
                                        // Raw r/w gates every lane
                                        bus_port.wr_lanes <= ~byte_n &
                                                {mz_bus_pkg::LANES{~rw_raw}};
                                        state             <= mz_bus_pkg::bus_settle;
                                end else begin
                                        state <= mz_bus_pkg::bus_ack;   // Early drop
                                end
                        end
                        mz_bus_pkg::bus_settle: begin
                                bus_port.wr_lanes <= '0;        // Write done this cycle
                                state             <= mz_bus_pkg::bus_read;
                        end
                        mz_bus_pkg::bus_read: begin
                                rd_wait <= ~rd_wait;
                                if (rd_wait) begin
                                        bus_port.en <= 1'b0;    // Hand RAM over
                                        if (addr_q.fields.word_idx ==
                                            idx_t'(pair_add_pkg::TRIGGER_WORD)) begin
                                                start <= 1'b1;
                                                state <= mz_bus_pkg::bus_batch;
                                        end else begin
                                                state <= mz_bus_pkg::bus_ack;
                                        end
                                end
                        end
                        mz_bus_pkg::bus_batch: begin
                                if (done) begin
                                        state <= mz_bus_pkg::bus_ack;
                                end
                        end
                        mz_bus_pkg::bus_ack: begin
                                dtack <= 1'b1;
                                state <= mz_bus_pkg::bus_hold;
                        end
                        mz_bus_pkg::bus_hold: begin
                                if (!as_detected) begin         // Host let go
                                        dtack <= 1'b0;
                                        state <= mz_bus_pkg::bus_idle;
                                end
                        end
                        default: state <= mz_bus_pkg::bus_idle;
                        endcase
                end
        end

        // No acknowledge while the batch started here is still running
        assert property (@(posedge buffered_clk) disable iff (!SYS_RST_N)
                state == mz_bus_pkg::bus_batch |-> !dtack);

        assert property (@(posedge buffered_clk) disable iff (!SYS_RST_N)
                state == mz_bus_pkg::bus_read |-> bus_port.wr_lanes == '0);

endmodule

/* src/pair_add_execute.sv */
`timescale 1ns/1ns

module pair_add_execute (
        input  logic       buffered_clk,
        input  logic       SYS_RST_N,
        input  logic       start,
        input  logic       irq_enable,
        input  logic       idle,        // Bus FSM idle
        output logic       busy,
        output logic       done,
        output logic       irq,
        ram_port_if.master seq_port
);

        typedef logic [mz_bus_pkg::WORD_IDX_W-1:0] idx_t;

        pair_add_pkg::add_state_e      state;
        idx_t                          op_idx;          // First operand of pair
        idx_t                          sum_idx;
        logic [mz_bus_pkg::DATA_W-1:0] op_a;
        logic [mz_bus_pkg::DATA_W-1:0] op_b;
        logic                          last_pair;
        logic                          pending;         // Interrupt held back

        assign last_pair = (sum_idx ==
                idx_t'(pair_add_pkg::RESULT_BASE + pair_add_pkg::PAIR_COUNT - 1));

        // ----------------------------------------------------------
        // RAM requests straight from state
        // ----------------------------------------------------------
        assign seq_port.en = busy && (state == pair_add_pkg::fetch_a ||
                state == pair_add_pkg::fetch_b || state == pair_add_pkg::write_sum);
        assign seq_port.wr_lanes =
                {mz_bus_pkg::LANES{busy && state == pair_add_pkg::write_sum}};
        assign seq_port.wdata = op_a + op_b;    // Wraps at 32 bits

        always_comb begin
                case (state)
                pair_add_pkg::fetch_b:   seq_port.word_idx = op_idx + idx_t'(1);
                pair_add_pkg::write_sum: seq_port.word_idx = sum_idx;
                default:                 seq_port.word_idx = op_idx;
                endcase
        end

        always_ff @(posedge buffered_clk) begin
                if (state == pair_add_pkg::take_a) begin
                        op_a <= seq_port.rdata;
                end
                if (state == pair_add_pkg::take_b) begin
                        op_b <= seq_port.rdata;
                end
        end

        // ----------------------------------------------------------
        // Sequencer
        // ----------------------------------------------------------
        always_ff @(posedge buffered_clk or negedge SYS_RST_N) begin
                if (!SYS_RST_N) begin
                        state   <= pair_add_pkg::fetch_a;
                        busy    <= 1'b0;
                        done    <= 1'b0;
                        op_idx  <= '0;
                        sum_idx <= '0;
                end else begin
                        done <= 1'b0;
                        if (!busy) begin
                                if (start) begin
                                        busy    <= 1'b1;
                                        state   <= pair_add_pkg::fetch_a;
                                        op_idx  <= idx_t'(pair_add_pkg::OPERAND_BASE);
                                        sum_idx <= idx_t'(pair_add_pkg::RESULT_BASE);
                                end
                        end else begin
                                case (state)
                                pair_add_pkg::fetch_a:   state <= pair_add_pkg::take_a;
                                pair_add_pkg::take_a:    state <= pair_add_pkg::fetch_b;
                                pair_add_pkg::fetch_b:   state <= pair_add_pkg::take_b;
                                pair_add_pkg::take_b:    state <= pair_add_pkg::write_sum;
                                pair_add_pkg::write_sum: state <= pair_add_pkg::advance;
                                default: begin                  // advance
                                        state   <= pair_add_pkg::fetch_a;
                                        op_idx  <= op_idx + idx_t'(2);
                                        sum_idx <= sum_idx + idx_t'(1);
                                        if (last_pair) begin    // Tenth sum written
                                                busy <= 1'b0;
                                                done <= 1'b1;
                                        end
                                end
                                endcase
                        end
                end
        end

        // Interrupt at done, or later once enabled and bus idle
        always_ff @(posedge buffered_clk or negedge SYS_RST_N) begin
                if (!SYS_RST_N) begin
                        irq     <= 1'b0;
                        pending <= 1'b0;
                end else begin
                        irq <= 1'b0;
                        if (done) begin
                                irq     <= irq_enable;
                                pending <= !irq_enable;
                        end else if (pending && irq_enable && idle) begin
                                irq     <= 1'b1;
                                pending <= 1'b0;
                        end
                end
        end

        assert property (@(posedge buffered_clk) disable iff (!SYS_RST_N)
                start |-> !busy);       // Decode waits in batch for done

        assert property (@(posedge buffered_clk) disable iff (!SYS_RST_N)
                irq |=> !irq);

endmodule

/* src/mz_bus_top.sv */
`timescale 1ns/1ns

module mz_bus_top (
        input  logic                          buffered_clk,
        input  logic                          SYS_RST_N,
        input  logic                          as,           // Address strobe
        input  logic                          rw,
        input  logic                          rw_raw,       // Low means write
        input  logic [mz_bus_pkg::LANES-1:0]  byte_n,
        input  logic [mz_bus_pkg::ADDR_W-1:0] addr,
        input  logic [mz_bus_pkg::DATA_W-1:0] wdata,
        input  logic                          irq_enable,   // DIP switch 0
        output logic [mz_bus_pkg::DATA_W-1:0] rdata,
        output logic                          rdata_oe,
        output logic                          dtack,
        output logic                          irq
);

        logic start;    // Decode to execute
        logic busy;     // Sequencer owns the RAM
        logic done;
        logic idle;     // Bus FSM idle

        ram_port_if bus_if ();
        ram_port_if seq_if ();

        mz_bus_decode u_decode (
                .buffered_clk (buffered_clk),
                .SYS_RST_N    (SYS_RST_N),
                .as           (as),
                .rw           (rw),
                .rw_raw       (rw_raw),
                .byte_n       (byte_n),
                .addr         (addr),
                .wdata        (wdata),
                .done         (done),
                .rdata        (rdata),
                .rdata_oe     (rdata_oe),
                .dtack        (dtack),
                .start        (start),
                .idle         (idle),
                .bus_port     (bus_if.master)
        );

        pair_add_execute u_execute (
                .buffered_clk (buffered_clk),
                .SYS_RST_N    (SYS_RST_N),
                .start        (start),
                .irq_enable   (irq_enable),
                .idle         (idle),
                .busy         (busy),
                .done         (done),
                .irq          (irq),
                .seq_port     (seq_if.master)
        );

        result_ram u_ram (
                .buffered_clk (buffered_clk),
                .SYS_RST_N    (SYS_RST_N),
                .busy         (busy),
                .bus_port     (bus_if.slave),
                .seq_port     (seq_if.slave)
        );

endmodule

/* verif/tb_mz_bus.sv */
`timescale 1ns/1ns

module tb_mz_bus;

        localparam int HALF_PERIOD     = 50;    // 100 ns clock
        localparam int CYCLES_PER_CASE = 200;   // Watchdog budget per case line
        localparam int HS_TIMEOUT      = 150;   // Longest wait for one dtack edge

        logic                          buffered_clk;
        logic                          SYS_RST_N;
        logic                          as;
        logic                          rw;
        logic                          rw_raw;
        logic [mz_bus_pkg::LANES-1:0]  byte_n;
        logic [mz_bus_pkg::ADDR_W-1:0] addr;
        logic [mz_bus_pkg::DATA_W-1:0] wdata;
        logic                          irq_enable;
        logic [mz_bus_pkg::DATA_W-1:0] rdata;
        logic                          rdata_oe;
        logic                          dtack;
        logic                          irq;

        // Case table, one entry per access
        logic [3:0]                        op_q   [$];  // 0 wr, 1 rd, 2 trigger, 3 raw-high wr
        logic [mz_bus_pkg::WORD_IDX_W-1:0] idx_q  [$];
        logic [mz_bus_pkg::DATA_W-1:0]     data_q [$];
        logic [mz_bus_pkg::LANES-1:0]      bn_q   [$];
        logic                              ie_q   [$];
        logic [mz_bus_pkg::DATA_W-1:0]     er_q   [$];  // Expected read word
        logic                              ei_q   [$];  // Expected irq

        int word_errs    = 0;
        int irq_errs     = 0;
        int dtack_errs   = 0;
        int oe_errs      = 0;
        int run_errs     = 0;                           // Handshake, file, watchdog
        int irq_pulses   = 0;                           // Pulses in current case
        int limit_cycles = 0;

        mz_bus_top DUT (
                .buffered_clk (buffered_clk),
                .SYS_RST_N    (SYS_RST_N),
                .as           (as),
                .rw           (rw),
                .rw_raw       (rw_raw),
                .byte_n       (byte_n),
                .addr         (addr),
                .wdata        (wdata),
                .irq_enable   (irq_enable),
                .rdata        (rdata),
                .rdata_oe     (rdata_oe),
                .dtack        (dtack),
                .irq          (irq)
        );

        always #HALF_PERIOD buffered_clk = ~buffered_clk;

        always @(negedge buffered_clk) begin
                if (SYS_RST_N && irq === 1'b1) begin
                        irq_pulses = irq_pulses + 1;    // One count per high cycle
                end
        end

        // ----------------------------------------------------------
        // Checks
        // ----------------------------------------------------------
        task automatic check_word(input logic [mz_bus_pkg::DATA_W-1:0] got,
                                  input logic [mz_bus_pkg::DATA_W-1:0] exp,
                                  input string what);
                if (got !== exp) begin
                        word_errs++;
                        $display("[ERROR] %0t ns %s got %h expected %h", $time, what, got, exp);
                end
        endtask

        task automatic check_irq(input bit got, input bit exp, input string what);
                if (got != exp) begin
                        irq_errs++;
                        $display("[ERROR] %0t ns %s got %0b expected %0b", $time, what, got, exp);
                end
        endtask

        task automatic check_dtack(input logic got, input logic exp, input string what);
                if (got !== exp) begin
                        dtack_errs++;
                        $display("[ERROR] %0t ns %s got %b expected %b", $time, what, got, exp);
                end
        endtask

        task automatic check_oe(input logic got, input logic exp, input string what);
                if (got !== exp) begin
                        oe_errs++;
                        $display("[ERROR] %0t ns %s got %b expected %b", $time, what, got, exp);
                end
        endtask

        // ----------------------------------------------------------
        // Bus host
        // ----------------------------------------------------------
        task automatic wait_dtack(input logic level, output bit ok);
                int n;
                ok = 1'b0;
                n  = 0;
                while (!ok && n < HS_TIMEOUT) begin
                        @(negedge buffered_clk);        // Outputs settled here
                        ok = (dtack === level);
                        n++;
                end
        endtask

        task automatic run_case(input int i, output bit ok);
                logic [mz_bus_pkg::DATA_W-1:0] got;
                int                            hold;
                string                         tag;
                hold = int'($urandom_range(3, 0));      // Host delay before dropping as
                tag  = $sformatf("case %0d word %0h", i, idx_q[i]);
                @(posedge buffered_clk);
                irq_pulses = 0;
                irq_enable <= ie_q[i];
                addr       <= {{(mz_bus_pkg::ADDR_W - mz_bus_pkg::WORD_IDX_W - 2){1'b0}},
                               idx_q[i], 2'b00};
                wdata      <= data_q[i];
                byte_n     <= bn_q[i];
                rw         <= (op_q[i] == 4'd1);
                rw_raw     <= (op_q[i] == 4'd1) || (op_q[i] == 4'd3);   // High blocks lanes
                @(posedge buffered_clk);
                as <= 1'b1;                             // Strobe after address setup
                wait_dtack(1'b1, ok);
                got = rdata;                            // Valid while rw and as high
                if (!ok) begin
                        $display("No dtack within %0d cycles on %s", HS_TIMEOUT, tag);
                end else begin
                        // Output enable only on a host read with as high
                        check_oe(rdata_oe, op_q[i] == 4'd1, {tag, " rdata_oe with as high"});
                        repeat (hold) begin
                                @(negedge buffered_clk);
                                check_dtack(dtack, 1'b1, {tag, " dtack with as held"});
                        end
                        @(posedge buffered_clk);
                        as <= 1'b0;
                        wait_dtack(1'b0, ok);
                        if (!ok) begin
                                $display("dtack stayed high after as dropped on %s", tag);
                        end else begin
                                check_oe(rdata_oe, 1'b0, {tag, " rdata_oe after as dropped"});
                                if (op_q[i] == 4'd1) begin
                                        check_word(got, er_q[i], {tag, " read data"});
                                end
                                check_irq(irq_pulses != 0, ei_q[i], {tag, " irq seen"});
                                check_irq(irq_pulses > 1, 1'b0, {tag, " extra irq pulses"});
                        end
                end
        endtask

        task automatic finish_run();
                $display("Errors word %0d irq %0d dtack %0d oe %0d run %0d",
                         word_errs, irq_errs, dtack_errs, oe_errs, run_errs);
                if (word_errs + irq_errs + dtack_errs + oe_errs + run_errs == 0) begin
                        $display("TEST PASS");
                end else begin
                        $display("TEST FAIL");
                end
                $finish;
        endtask

        // ----------------------------------------------------------
        // Case replay
        // ----------------------------------------------------------
        initial begin : replay
                int                                fd;
                int                                n;
                int                                i;
                bit                                ok;
                string                             line;
                logic [3:0]                        op;
                logic [mz_bus_pkg::WORD_IDX_W-1:0] idx;
                logic [mz_bus_pkg::DATA_W-1:0]     d;
                logic [mz_bus_pkg::LANES-1:0]      bn;
                logic                              ie;
                logic [mz_bus_pkg::DATA_W-1:0]     er;
                logic                              ei;
                void'($urandom(32'h97f0_3cee));
                buffered_clk = 1'b0;
                SYS_RST_N    = 1'b0;
                as           = 1'b0;
                rw           = 1'b0;
                rw_raw       = 1'b1;
                byte_n       = '1;
                addr         = '0;
                wdata        = '0;
                irq_enable   = 1'b0;
                fd = $fopen("verif/mz_bus_cases.txt", "r");
                if (fd == 0) begin
                        $display("Could not open verif/mz_bus_cases.txt");
                        run_errs++;
                end else begin
                        while (!$feof(fd)) begin
                                n = $fgets(line, fd);
                                if (n > 0 && line.getc(0) != "#") begin   // Skip header
                                        n = $sscanf(line, "%h %h %h %h %h %h %h",
                                                    op, idx, d, bn, ie, er, ei);
                                        if (n == 7) begin
                                                op_q.push_back(op);
                                                idx_q.push_back(idx);
                                                data_q.push_back(d);
                                                bn_q.push_back(bn);
                                                ie_q.push_back(ie);
                                                er_q.push_back(er);
                                                ei_q.push_back(ei);
                                        end
                                end
                        end
                        $fclose(fd);
                        if (op_q.size() == 0) begin
                                $display("The case file held no cases");
                                run_errs++;
                        end
                end
                limit_cycles = op_q.size() * CYCLES_PER_CASE + 10;
                repeat (3) @(posedge buffered_clk);
                SYS_RST_N <= 1'b1;
                @(negedge buffered_clk);
                check_dtack(dtack, 1'b0, "dtack after reset");
                ok = 1'b1;
                for (i = 0; i < op_q.size() && ok; i++) begin
                        repeat ($urandom_range(3, 0)) @(posedge buffered_clk); // Idle gap
                        run_case(i, ok);
                end
                if (!ok) begin
                        run_errs++;
                end
                finish_run();
        end

        // Whole run bounded by case count
        initial begin : watchdog
                wait (limit_cycles != 0);
                repeat (limit_cycles) @(posedge buffered_clk);
                $display("Watchdog ran out after %0d cycles and stopped the run", limit_cycles);
                run_errs++;
                finish_run();
        end

endmodule

/* verif/mz_bus_cases.txt */
# op (0 write, 1 read, 2 trigger, 3 write with rw_raw high) word data byte_n irq_enable
# exp_rdata (checked on reads only) exp_irq, all hex, word index in hex
0 005 cafef00d 0 1 00000000 0
1 005 00000000 0 1 cafef00d 0
0 028 11223344 0 1 00000000 0
0 028 aabbccdd a 1 00000000 0
1 028 00000000 0 1 11bb33dd 0
3 028 ffffffff 0 1 00000000 0
1 028 00000000 0 1 11bb33dd 0
0 001 00000001 0 1 00000000 0
0 002 00000002 0 1 00000000 0
0 003 10000000 0 1 00000000 0
0 004 01000000 0 1 00000000 0
0 005 12345678 0 1 00000000 0
0 006 11111111 0 1 00000000 0
0 007 fffffff0 0 1 00000000 0
0 008 00000020 0 1 00000000 0
0 009 0000ffff 0 1 00000000 0
0 00a 00000001 0 1 00000000 0
0 00b a5a5a5a5 0 1 00000000 0
0 00c 5a5a5a5a 0 1 00000000 0
0 00d 00000100 0 1 00000000 0
0 00e 00000200 0 1 00000000 0
0 00f 7fffffff 0 1 00000000 0
0 010 00000001 0 1 00000000 0
0 011 dead0000 0 1 00000000 0
0 012 0000beef 0 1 00000000 0
0 013 0bad0000 0 1 00000000 0
0 014 0000f00d 0 1 00000000 0
2 000 00000000 0 1 00000000 1
1 015 00000000 0 1 00000003 0
1 016 00000000 0 1 11000000 0
1 017 00000000 0 1 23456789 0
1 018 00000000 0 1 00000010 0
1 019 00000000 0 1 00010000 0
1 01a 00000000 0 1 ffffffff 0
1 01b 00000000 0 1 00000300 0
1 01c 00000000 0 1 80000000 0
1 01d 00000000 0 1 deadbeef 0
1 01e 00000000 0 1 0badf00d 0
2 000 00000000 0 0 00000000 0
1 005 00000000 0 0 12345678 0
1 015 00000000 0 1 00000003 1
1 018 00000000 0 1 00000010 0

/* sources.f */
common/mz_bus_pkg.sv
common/pair_add_pkg.sv
common/ram_port_if.sv
src/result_ram.sv
src/mz_bus_decode.sv
src/pair_add_execute.sv
src/mz_bus_top.sv
verif/tb_mz_bus.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f \
        --top-module tb_mz_bus --Mdir obj_dir -o tb_mz_bus_sim

./obj_dir/tb_mz_bus_sim > sim.log 2>&1
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
        exit 0
fi
exit 1
